// ==== filelist.f ====
+incdir+verif
design/aes_pkg.sv
design/aes_sbox.sv
design/aes_round.sv
design/aes_key_schedule.sv
design/aes_round_counter.sv
design/aes_ctrl_fsm.sv
design/aes_wb_regs.sv
design/aes_wb_top.sv
verif/tb_aes_wb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tb_aes_wb \
    -Mdir obj_dir -o sim_aes > build.log 2>&1 \
    && ./obj_dir/sim_aes > sim.log 2>&1 \
    && grep -q "Verification passed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== verif/tb_aes_tasks.svh ====
`ifndef TB_AES_TASKS_SVH
`define TB_AES_TASKS_SVH
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wishbone master with one access at a time

task automatic wait_for_ack();
    @(negedge clk);
    while (!ack)
    begin
        @(negedge clk);
    end
endtask

task automatic bus_write(input logic [ADR_W-1:0] a, input logic [WORD_W-1:0] d);
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= 1'b1;
    adr   <= a;
    dat_w <= d;
    accesses++;
    wait_for_ack();
    @(posedge clk);  // write lands on this edge
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
endtask

task automatic bus_read(input logic [ADR_W-1:0] a, output logic [WORD_W-1:0] d);
    @(posedge clk);
    cyc <= 1'b1;
    stb <= 1'b1;
    we  <= 1'b0;
    adr <= a;
    accesses++;
    wait_for_ack();
    d = dat_r;  // valid while ack is high
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
endtask

// read that keeps cyc and stb up for extra cycles after the ack
task automatic bus_read_held(input logic [ADR_W-1:0] a, input int extra_cycles,
                             output logic [WORD_W-1:0] d);
    @(posedge clk);
    cyc <= 1'b1;
    stb <= 1'b1;
    we  <= 1'b0;
    adr <= a;
    accesses++;
    wait_for_ack();
    d = dat_r;
    repeat (extra_cycles + 1) @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// block level tasks with word 0 as the top 32 bits

task automatic write_block(input logic [BLOCK_W-1:0] key, input logic [BLOCK_W-1:0] pt);
    for (int i = 0; i < NUM_COLS; i++)
    begin
        bus_write(ADR_W'(ADR_KEY0 + i), key[BLOCK_W-1-WORD_W*i -: WORD_W]);
    end
    for (int i = 0; i < NUM_COLS; i++)
    begin
        bus_write(ADR_W'(ADR_PT0 + i), pt[BLOCK_W-1-WORD_W*i -: WORD_W]);
    end
endtask

task automatic start_encrypt();
    logic [WORD_W-1:0] ctrl;
    ctrl                 = '0;
    ctrl[CTRL_START_BIT] = 1'b1;
    bus_write(ADR_CTRL, ctrl);
endtask

task automatic wait_done();
    logic [WORD_W-1:0] status;
    status = '0;
    while (!status[STAT_DONE_BIT])
    begin
        bus_read(ADR_STATUS, status);
    end
endtask

task automatic read_result(output logic [BLOCK_W-1:0] ct);
    logic [WORD_W-1:0] word;
    for (int i = 0; i < NUM_COLS; i++)
    begin
        bus_read(ADR_W'(ADR_CT0 + i), word);
        ct[BLOCK_W-1-WORD_W*i -: WORD_W] = word;
    end
endtask

task automatic encrypt_block(input logic [BLOCK_W-1:0] key, input logic [BLOCK_W-1:0] pt,
                             output logic [BLOCK_W-1:0] ct);
    write_block(key, pt);
    start_encrypt();
    wait_done();
    read_result(ct);
endtask

`default_nettype wire
`endif

// ==== verif/tb_aes_wb.sv ====
`default_nettype none

module tb_aes_wb;
    import aes_pkg::*;

    // six tests come to roughly 400 bus cycles
    localparam int unsigned TIMEOUT_CYCLES = 2000;

    // fips-197 appendix c.1 and appendix b
    localparam logic [BLOCK_W-1:0] C1_KEY = 128'h000102030405060708090a0b0c0d0e0f;
    localparam logic [BLOCK_W-1:0] C1_PT  = 128'h00112233445566778899aabbccddeeff;
    localparam logic [BLOCK_W-1:0] C1_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    localparam logic [BLOCK_W-1:0] B_KEY  = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam logic [BLOCK_W-1:0] B_PT   = 128'h3243f6a8885a308d313198a2e0370734;
    localparam logic [BLOCK_W-1:0] B_CT   = 128'h3925841d02dc09fbdc118597196a0b32;

    logic              clk;
    logic              rst;
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADR_W-1:0]  adr;
    logic [WORD_W-1:0] dat_w;
    logic [WORD_W-1:0] dat_r;
    logic              ack;

    int          seed;
    int          errors = 0;
    int          errors_at_start = 0;
    int          checks = 0;
    int          tests = 0;
    int          accesses = 0;
    int          ack_count = 0;
    int unsigned cycle_count = 0;

    aes_wb_top u_aes_wb_top (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    `include "tb_aes_tasks.svh"

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (ack)
            ack_count <= ack_count + 1;  // ack-high cycles seen
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus protocol
    assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
    else
    begin
        errors++;
        $display("FAIL %0t: ack stayed high for more than one cycle", $time);
    end

    assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> $past(cyc && stb))
    else
    begin
        errors++;
        $display("FAIL %0t: ack rose without cyc and stb", $time);
    end

    task automatic expect_equal(input string what, input logic [BLOCK_W-1:0] got,
                                input logic [BLOCK_W-1:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("FAIL %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    initial
    begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("run timed out after %0d cycles", cycle_count);
        $display("Verification failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    initial
    begin
        logic [BLOCK_W-1:0] ct;
        logic [BLOCK_W-1:0] ct_again;
        logic [BLOCK_W-1:0] rkey;
        logic [BLOCK_W-1:0] rpt;
        logic [WORD_W-1:0]  word;

        seed  = 70985;
        rst   = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        bus_read(ADR_STATUS, word);
        expect_equal("status after reset", word, '0);
        read_result(ct);
        expect_equal("ciphertext after reset", ct, '0);
        finish_test("reset values");

        encrypt_block(C1_KEY, C1_PT, ct);
        expect_equal("fips c.1 ciphertext", ct, C1_CT);
        finish_test("fips-197 c.1");

        encrypt_block(B_KEY, B_PT, ct);
        expect_equal("fips b ciphertext", ct, B_CT);
        finish_test("fips-197 appendix b");

        for (int i = 0; i < NUM_COLS; i++)
        begin
            rkey[BLOCK_W-1-WORD_W*i -: WORD_W] = $random(seed);
            rpt[BLOCK_W-1-WORD_W*i -: WORD_W]  = $random(seed);
        end
        write_block(rkey, rpt);
        for (int i = 0; i < NUM_COLS; i++)
        begin
            bus_read(ADR_W'(ADR_KEY0 + i), word);
            expect_equal("key readback", word, rkey[BLOCK_W-1-WORD_W*i -: WORD_W]);
            bus_read(ADR_W'(ADR_PT0 + i), word);
            expect_equal("plaintext readback", word, rpt[BLOCK_W-1-WORD_W*i -: WORD_W]);
        end
        encrypt_block(rkey, rpt, ct);
        encrypt_block(rkey, rpt, ct_again);
        expect_equal("repeated random block", ct_again, ct);
        finish_test("random readback and repeat");

        write_block(B_KEY, B_PT);
        start_encrypt();
        bus_read(ADR_STATUS, word);
        expect_equal("busy right after start", word[STAT_BUSY_BIT], 1'b1);
        expect_equal("done right after start", word[STAT_DONE_BIT], 1'b0);
        bus_write(ADR_KEY0, ~B_KEY[BLOCK_W-1 -: WORD_W]);  // a restart would pick this up
        start_encrypt();  // lands in the middle of the rounds
        wait_done();
        read_result(ct);
        expect_equal("result after start while busy", ct, B_CT);
        bus_read(ADR_STATUS, word);
        expect_equal("busy after completion", word[STAT_BUSY_BIT], 1'b0);
        expect_equal("done after completion", word[STAT_DONE_BIT], 1'b1);
        finish_test("start while busy");

        word = $random(seed);
        bus_write(ADR_CT0, word);
        read_result(ct);
        expect_equal("ciphertext after write to ct0", ct, B_CT);
        bus_read_held(4'd10, 3, word);
        expect_equal("unmapped address 10", word, '0);
        bus_read(4'd11, word);
        expect_equal("unmapped address 11", word, '0);

        // cyc alone, then stb alone
        @(posedge clk);
        cyc <= 1'b1;
        repeat (2) @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b1;
        repeat (2) @(posedge clk);
        stb <= 1'b0;
        @(negedge clk);
        expect_equal("ack cycles against accesses", ack_count, accesses);
        finish_test("bus protocol");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/aes_wb_top.sv ====
`default_nettype none

module aes_wb_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cyc,
    input  logic                       stb,
    input  logic                       we,
    input  logic [aes_pkg::ADR_W-1:0]  adr,
    input  logic [aes_pkg::WORD_W-1:0] dat_w,
    output logic [aes_pkg::WORD_W-1:0] dat_r,
    output logic                       ack
);
    import aes_pkg::*;

    logic       start;
    logic       busy;
    logic       done;
    logic       load;
    logic       step;
    logic       last_round;
    aes_state_t key;
    aes_state_t plaintext;
    aes_state_t result;
    aes_state_t round_key;

    aes_wb_regs u_wb_regs (
        .clk       (clk),
        .rst       (rst),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .dat_w     (dat_w),
        .dat_r     (dat_r),
        .ack       (ack),
        .busy      (busy),
        .done      (done),
        .result    (result),
        .key       (key),
        .plaintext (plaintext),
        .start     (start)
    );

    aes_ctrl_fsm u_ctrl_fsm (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .last_round (last_round),
        .load       (load),
        .step       (step),
        .busy       (busy),
        .done       (done)
    );

    aes_round_counter u_round_counter (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .step       (step),
        .last_round (last_round)
    );

    aes_key_schedule u_key_schedule (
        .clk       (clk),
        .load      (load),
        .step      (step),
        .key_in    (key),
        .round_key (round_key)
    );

    aes_round u_round (
        .clk           (clk),
        .load          (load),
        .step          (step),
        .last_round    (last_round),
        .state_in      (plaintext),
        .plaintext_key (key),
        .round_key     (round_key),
        .state_out     (result)
    );

endmodule

`default_nettype wire

// ==== design/aes_wb_regs.sv ====
`default_nettype none

module aes_wb_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cyc,
    input  logic                       stb,
    input  logic                       we,
    input  logic [aes_pkg::ADR_W-1:0]  adr,
    input  logic [aes_pkg::WORD_W-1:0] dat_w,
    output logic [aes_pkg::WORD_W-1:0] dat_r,
    output logic                       ack,
    input  logic                       busy,
    input  logic                       done,
    input  aes_pkg::aes_state_t        result,
    output aes_pkg::aes_state_t        key,
    output aes_pkg::aes_state_t        plaintext,
    output logic                       start
);
    import aes_pkg::*;

    logic              hold;    // access already acked, waiting for stb low
    logic              wr_en;
    logic              done_q;
    aes_state_t        ct;
    logic [WORD_W-1:0] status;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // wishbone handshake
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ack  <= 1'b0;
            hold <= 1'b0;
        end
        else
        begin
            ack <= cyc && stb && !ack && !hold;
            if (ack)
                hold <= 1'b1;
            else if (!stb)
                hold <= 1'b0;
        end
    end

    assign wr_en = ack && we;
    assign start = wr_en && (adr == ADR_CTRL) && dat_w[CTRL_START_BIT];

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            case (adr)
                ADR_KEY0, ADR_KEY1, ADR_KEY2, ADR_KEY3:
                    key.cols[adr[1:0]] <= dat_w;
                ADR_PT0, ADR_PT1, ADR_PT2, ADR_PT3:
                    plaintext.cols[adr[1:0]] <= dat_w;
                default:
                    ;  // read-only or unmapped
            endcase
        end
    end

    // ciphertext taken once, on the rising edge of done
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            done_q <= 1'b0;
            ct     <= '0;
        end
        else
        begin
            done_q <= done;
            if (done && !done_q)
                ct <= result;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read mux
    always_comb
    begin
        status                = '0;
        status[STAT_BUSY_BIT] = busy;
        status[STAT_DONE_BIT] = done;
    end

    always_comb
    begin
        case (adr)
            ADR_KEY0, ADR_KEY1, ADR_KEY2, ADR_KEY3:
                dat_r = key.cols[adr[1:0]];
            ADR_PT0, ADR_PT1, ADR_PT2, ADR_PT3:
                dat_r = plaintext.cols[adr[1:0]];
            ADR_STATUS:
                dat_r = status;
            ADR_CT0, ADR_CT1, ADR_CT2, ADR_CT3:
                dat_r = ct.cols[adr[1:0]];
            default:
                dat_r = '0;  // ctrl is write-only
        endcase
    end

endmodule

`default_nettype wire

// ==== design/aes_ctrl_fsm.sv ====
`default_nettype none

module aes_ctrl_fsm (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic last_round,
    output logic load,
    output logic step,
    output logic busy,
    output logic done
);
    import aes_pkg::*;

    logic [ST_W-1:0] state_q;
    logic [ST_W-1:0] state_d;
    logic            accept;

    assign accept = start && ((state_q == ST_IDLE) || (state_q == ST_DONE));

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ST_IDLE, ST_DONE:
                if (start)
                    state_d = ST_INIT;
            ST_INIT:
                state_d = ST_ROUND;
            ST_ROUND:
                if (last_round)
                    state_d = ST_DONE;
            default:
                state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= ST_IDLE;
            done    <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            if (accept)
                done <= 1'b0;
            else if (step && last_round)
                done <= 1'b1;  // same edge as the final state update
        end
    end

    assign load = (state_q == ST_INIT);
    assign step = (state_q == ST_ROUND);
    assign busy = load || step;

endmodule

`default_nettype wire

// ==== design/aes_round_counter.sv ====
`default_nettype none

module aes_round_counter (
    input  logic clk,
    input  logic rst,
    input  logic load,
    input  logic step,
    output logic last_round
);
    import aes_pkg::*;

    logic [ROUND_W-1:0] count;

    always_ff @(posedge clk)
    begin
        if (rst)
            count <= '0;
        else if (load)
            count <= ROUND_W'(1);
        else if (step)
            count <= count + 1'b1;
    end

    assign last_round = (count == NUM_ROUNDS);

endmodule

`default_nettype wire

// ==== design/aes_key_schedule.sv ====
`default_nettype none

module aes_key_schedule (
    input  logic               clk,
    input  logic               load,
    input  logic               step,
    input  aes_pkg::aes_state_t key_in,
    output aes_pkg::aes_state_t round_key
);
    import aes_pkg::*;

    aes_state_t        key_q;     // key of the round just finished
    aes_state_t        key_next;
    logic [BYTE_W-1:0] rcon_q;
    logic [WORD_W-1:0] rot_word;
    logic [WORD_W-1:0] sub_word;

    assign rot_word = {key_q.cols[NUM_COLS-1][WORD_W-BYTE_W-1:0],
                       key_q.cols[NUM_COLS-1][WORD_W-1:WORD_W-BYTE_W]};

    // subword
    for (genvar i = 0; i < WORD_W / BYTE_W; i++)
    begin : g_sub
        aes_sbox u_sbox (
            .in  (rot_word[BYTE_W*i +: BYTE_W]),
            .out (sub_word[BYTE_W*i +: BYTE_W])
        );
    end

    always_comb
    begin
        key_next.cols[0] = key_q.cols[0] ^ sub_word ^ {rcon_q, {(WORD_W-BYTE_W){1'b0}}};
        for (int c = 1; c < NUM_COLS; c++)
        begin
            key_next.cols[c] = key_q.cols[c] ^ key_next.cols[c-1];
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            key_q  <= key_in;
            rcon_q <= RCON_INIT;
        end
        else if (step)
        begin
            key_q  <= key_next;
            rcon_q <= xtime(rcon_q);  // 0x80 wraps to 0x1b
        end
    end

    assign round_key = key_next;  // used by the round in the same cycle

endmodule

`default_nettype wire

// ==== design/aes_round.sv ====
`default_nettype none

module aes_round (
    input  logic               clk,
    input  logic               load,
    input  logic               step,
    input  logic               last_round,
    input  aes_pkg::aes_state_t state_in,       // plaintext block
    input  aes_pkg::aes_state_t plaintext_key,  // cipher key, added once at load
    input  aes_pkg::aes_state_t round_key,
    output aes_pkg::aes_state_t state_out
);
    import aes_pkg::*;

    aes_state_t        state_q;
    aes_state_t        shifted;
    aes_state_t        mixed;
    aes_state_t        round_out;
    logic [BYTE_W-1:0] sub_bytes [NUM_BYTES];

    // {2 3 1 1} circulant over one column
    function automatic logic [WORD_W-1:0] mix_column(input logic [WORD_W-1:0] col);
        logic [BYTE_W-1:0] a0, a1, a2, a3;
        {a0, a1, a2, a3} = col;
        mix_column = {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                      a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                      a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                      xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
    endfunction

    for (genvar i = 0; i < NUM_BYTES; i++)
    begin : g_sub
        aes_sbox u_sbox (
            .in  (state_q.bytes[i]),
            .out (sub_bytes[i])
        );
    end

    always_comb
    begin
        // row r rotates left by r columns
        for (int i = 0; i < NUM_BYTES; i++)
        begin
            shifted.bytes[i] = sub_bytes[(i % 4) + 4 * (((i / 4) + (i % 4)) % 4)];
        end
        for (int c = 0; c < NUM_COLS; c++)
        begin
            mixed.cols[c] = mix_column(shifted.cols[c]);
        end
        round_out = (last_round ? shifted : mixed) ^ round_key;  // no mixcolumns in round 10
    end

    always_ff @(posedge clk)
    begin
        if (load)
            state_q <= state_in ^ plaintext_key;
        else if (step)
            state_q <= round_out;
    end

    assign state_out = state_q;

endmodule

`default_nettype wire

// ==== design/aes_sbox.sv ====
`default_nettype none

module aes_sbox (
    input  logic [aes_pkg::BYTE_W-1:0] in,
    output logic [aes_pkg::BYTE_W-1:0] out
);
    import aes_pkg::*;

    logic [0:BYTE_W-1] x;  // x[0] is the msb
    logic [0:BYTE_W-1] s;
    logic [21:1]       y;
    logic [67:0]       t;
    logic [17:0]       z;

    always_comb
    begin
        x = in;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // top linear layer
        y[14] = x[3] ^ x[5];
        y[13] = x[0] ^ x[6];
        y[9]  = x[0] ^ x[3];
        y[8]  = x[0] ^ x[5];
        t[0]  = x[1] ^ x[2];
        y[1]  = t[0] ^ x[7];
        y[4]  = y[1] ^ x[3];
        y[12] = y[13] ^ y[14];
        y[2]  = y[1] ^ x[0];
        y[5]  = y[1] ^ x[6];
        y[3]  = y[5] ^ y[8];
        t[1]  = x[4] ^ y[12];
        y[15] = t[1] ^ x[5];
        y[20] = t[1] ^ x[1];
        y[6]  = y[15] ^ x[7];
        y[10] = y[15] ^ t[0];
        y[11] = y[20] ^ y[9];
        y[7]  = x[7] ^ y[11];
        y[17] = y[10] ^ y[11];
        y[19] = y[10] ^ y[8];
        y[16] = t[0] ^ y[11];
        y[21] = y[13] ^ y[16];
        y[18] = x[0] ^ y[16];

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // shared nonlinear middle, gf(2^4) inversion
        t[2]  = y[12] & y[15];
        t[3]  = y[3] & y[6];
        t[4]  = t[3] ^ t[2];
        t[5]  = y[4] & x[7];
        t[6]  = t[5] ^ t[2];
        t[7]  = y[13] & y[16];
        t[8]  = y[5] & y[1];
        t[9]  = t[8] ^ t[7];
        t[10] = y[2] & y[7];
        t[11] = t[10] ^ t[7];
        t[12] = y[9] & y[11];
        t[13] = y[14] & y[17];
        t[14] = t[13] ^ t[12];
        t[15] = y[8] & y[10];
        t[16] = t[15] ^ t[12];
        t[17] = t[4] ^ t[14];
        t[18] = t[6] ^ t[16];
        t[19] = t[9] ^ t[14];
        t[20] = t[11] ^ t[16];
        t[21] = t[17] ^ y[20];
        t[22] = t[18] ^ y[19];
        t[23] = t[19] ^ y[21];
        t[24] = t[20] ^ y[18];
        t[25] = t[21] ^ t[22];
        t[26] = t[21] & t[23];
        t[27] = t[24] ^ t[26];
        t[28] = t[25] & t[27];
        t[29] = t[28] ^ t[22];
        t[30] = t[23] ^ t[24];
        t[31] = t[22] ^ t[26];
        t[32] = t[31] & t[30];
        t[33] = t[32] ^ t[24];
        t[34] = t[23] ^ t[33];
        t[35] = t[27] ^ t[33];
        t[36] = t[24] & t[35];
        t[37] = t[36] ^ t[34];
        t[38] = t[27] ^ t[36];
        t[39] = t[29] & t[38];
        t[40] = t[25] ^ t[39];
        t[41] = t[40] ^ t[37];
        t[42] = t[29] ^ t[33];
        t[43] = t[29] ^ t[40];
        t[44] = t[33] ^ t[37];
        t[45] = t[42] ^ t[41];
        z[0]  = t[44] & y[15];
        z[1]  = t[37] & y[6];
        z[2]  = t[33] & x[7];
        z[3]  = t[43] & y[16];
        z[4]  = t[40] & y[1];
        z[5]  = t[29] & y[7];
        z[6]  = t[42] & y[11];
        z[7]  = t[45] & y[17];
        z[8]  = t[41] & y[10];
        z[9]  = t[44] & y[12];
        z[10] = t[37] & y[3];
        z[11] = t[33] & y[4];
        z[12] = t[43] & y[13];
        z[13] = t[40] & y[5];
        z[14] = t[29] & y[2];
        z[15] = t[42] & y[9];
        z[16] = t[45] & y[14];
        z[17] = t[41] & y[8];

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // bottom linear layer, affine 0x63 folded into the inverted bits
        t[46] = z[15] ^ z[16];
        t[47] = z[10] ^ z[11];
        t[48] = z[5] ^ z[13];
        t[49] = z[9] ^ z[10];
        t[50] = z[2] ^ z[12];
        t[51] = z[2] ^ z[5];
        t[52] = z[7] ^ z[8];
        t[53] = z[0] ^ z[3];
        t[54] = z[6] ^ z[7];
        t[55] = z[16] ^ z[17];
        t[56] = z[12] ^ t[48];
        t[57] = t[50] ^ t[53];
        t[58] = z[4] ^ t[46];
        t[59] = z[3] ^ t[54];
        t[60] = t[46] ^ t[57];
        t[61] = z[14] ^ t[57];
        t[62] = t[52] ^ t[58];
        t[63] = t[49] ^ t[58];
        t[64] = z[4] ^ t[59];
        t[65] = t[61] ^ t[62];
        t[66] = z[1] ^ t[63];
        t[67] = t[64] ^ t[65];
        s[0]  = t[59] ^ t[63];
        s[3]  = t[53] ^ t[66];
        s[4]  = t[51] ^ t[66];
        s[5]  = t[47] ^ t[65];
        s[6]  = ~(t[56] ^ t[62]);
        s[7]  = ~(t[48] ^ t[60]);
        s[1]  = ~(t[64] ^ s[3]);
        s[2]  = ~(t[55] ^ t[67]);

        out = s;
    end

endmodule

`default_nettype wire

// ==== design/aes_pkg.sv ====
`default_nettype none

package aes_pkg;

    localparam int BLOCK_W   = 128;
    localparam int WORD_W    = 32;
    localparam int BYTE_W    = 8;
    localparam int NUM_BYTES = BLOCK_W / BYTE_W;
    localparam int NUM_COLS  = BLOCK_W / WORD_W;

    localparam int ROUND_W = 4;
    localparam logic [ROUND_W-1:0] NUM_ROUNDS = 4'd10;  // aes-128

    localparam logic [BYTE_W-1:0] RCON_INIT = 8'h01;
    localparam logic [BYTE_W-1:0] GF_POLY   = 8'h1b;  // x^8 + x^4 + x^3 + x + 1

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register map, word addresses
    localparam int ADR_W = 4;
    localparam logic [ADR_W-1:0] ADR_KEY0   = 4'd0;
    localparam logic [ADR_W-1:0] ADR_KEY1   = 4'd1;
    localparam logic [ADR_W-1:0] ADR_KEY2   = 4'd2;
    localparam logic [ADR_W-1:0] ADR_KEY3   = 4'd3;
    localparam logic [ADR_W-1:0] ADR_PT0    = 4'd4;
    localparam logic [ADR_W-1:0] ADR_PT1    = 4'd5;
    localparam logic [ADR_W-1:0] ADR_PT2    = 4'd6;
    localparam logic [ADR_W-1:0] ADR_PT3    = 4'd7;
    localparam logic [ADR_W-1:0] ADR_CTRL   = 4'd8;
    localparam logic [ADR_W-1:0] ADR_STATUS = 4'd9;
    localparam logic [ADR_W-1:0] ADR_CT0    = 4'd12;
    localparam logic [ADR_W-1:0] ADR_CT1    = 4'd13;
    localparam logic [ADR_W-1:0] ADR_CT2    = 4'd14;
    localparam logic [ADR_W-1:0] ADR_CT3    = 4'd15;

    localparam int CTRL_START_BIT = 0;
    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_DONE_BIT  = 1;

    // control fsm encoding
    localparam int ST_W = 2;
    localparam logic [ST_W-1:0] ST_IDLE  = 2'd0;
    localparam logic [ST_W-1:0] ST_INIT  = 2'd1;
    localparam logic [ST_W-1:0] ST_ROUND = 2'd2;
    localparam logic [ST_W-1:0] ST_DONE  = 2'd3;

    // byte 0 / column 0 sit in the top bits, fips column-major order
    typedef union packed {
        logic [0:NUM_BYTES-1][BYTE_W-1:0] bytes;
        logic [0:NUM_COLS-1][WORD_W-1:0]  cols;
    } aes_state_t;

    // multiply by x in gf(2^8)
    function automatic logic [BYTE_W-1:0] xtime(input logic [BYTE_W-1:0] b);
        xtime = {b[BYTE_W-2:0], 1'b0} ^ (b[BYTE_W-1] ? GF_POLY : 8'h00);
    endfunction

endpackage

`default_nettype wire
